// File: hdl/lsu_types_pkg.sv
// word widths, byte-lane types and access-size encoding, imported by the load/store unit and testbench
package lsu_types_pkg;

  ////////////////////
  // data path geometry
  ////////////////////

  localparam int unsigned BYTES_PER_WORD = 4;  // byte lanes per data word

  // one data or address word
  typedef logic [8*BYTES_PER_WORD-1:0] word_t;

  // byte enable, one bit per lane
  typedef logic [BYTES_PER_WORD-1:0] be_t;

  // byte offset inside a word
  typedef logic [$clog2(BYTES_PER_WORD)-1:0] offset_t;

  ////////////////////
  // access size
  ////////////////////

  // encoding 3 is not named and decodes as a byte everywhere
  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,  // 32 bit
    SIZE_HALF = 2'd1,  // 16 bit
    SIZE_BYTE = 2'd2   // 8 bit
  } size_e;

endpackage

// File: hdl/lsu_bus_pkg.sv
// bundles exchanged between execute stage, load/store unit and data memory port
package lsu_bus_pkg;

  import lsu_types_pkg::*;

  ////////////////////
  // execute side
  ////////////////////

  // request presented by the execute stage, held until ready_ex_o
  typedef struct packed {
    logic    req;             // access wanted, level
    logic    we;              // store when set, load otherwise
    size_e   size;            // word, halfword or byte
    word_t   wdata;           // store data as held in the register
    offset_t reg_offset;      // byte offset of the data inside the register
    logic    sign_ext;        // sign extend loaded halfwords and bytes
    word_t   op_a;            // base operand
    word_t   op_b;            // increment operand
    logic    use_incr;        // address = op_a + op_b
    logic    misaligned_2nd;  // second part of a split access
  } ex_req_t;

  ////////////////////
  // memory side
  ////////////////////

  // request/grant port, fields held until granted
  typedef struct packed {
    logic  req;
    word_t addr;   // byte address, low bits kept for the slave
    logic  we;
    be_t   be;     // lane enables
    word_t wdata;  // already rotated onto the lanes
  } mem_req_t;

  // what the load path needs to remember between grant and rvalid
  typedef struct packed {
    size_e   size;
    offset_t offset;
    logic    sign_ext;
    logic    we;
  } load_attr_t;

endpackage

// File: hdl/lsu_store_path.sv
// address, byte-enable and store-data generation plus misalignment detection for the LSU top
`timescale 1ns/1ns

module lsu_store_path
  import lsu_types_pkg::*;
  import lsu_bus_pkg::*;
(
  input  ex_req_t  ex_req_i,      // request from execute stage
  output mem_req_t mem_req_o,     // fields for the memory port, req left low
  output offset_t  offset_o,      // byte offset of the current address
  output logic     misaligned_o   // access needs a second part
);

  word_t   addr;          // generated byte address
  offset_t addr_offset;   // lane of the first byte
  offset_t rot_bytes;     // left rotation of store data in bytes
  be_t     be;
  word_t   wdata_rot;

  ////////////////////
  // address generation
  ////////////////////

  assign addr = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;

  assign addr_offset = addr[1:0];

  ////////////////////
  // byte enables
  ////////////////////

  // first part starts at the address lane and runs up to lane 3,
  // second part covers whatever spilled into the next word
  always_comb
  begin
    case (ex_req_i.size)
      SIZE_WORD:
      begin
        if (!ex_req_i.misaligned_2nd)
          be = be_t'(4'b1111 << addr_offset);     // lanes k..3
        else
          be = ~be_t'(4'b1111 << addr_offset);    // lanes 0..k-1
      end

      SIZE_HALF:
      begin
        if (!ex_req_i.misaligned_2nd)
          be = be_t'(4'b0011 << addr_offset);     // top lane drops off at offset 3
        else
          be = 4'b0001;                           // only the spilled upper byte
      end

      default:
      begin
        be = be_t'(4'b0001 << addr_offset);       // byte, encodings 2 and 3
      end
    endcase
  end

  ////////////////////
  // store data rotation
  ////////////////////

  // register byte at reg_offset has to land on lane addr_offset
  assign rot_bytes = addr_offset - ex_req_i.reg_offset;

  always_comb
  begin
    case (rot_bytes)
      2'd0:    wdata_rot = ex_req_i.wdata;
      2'd1:    wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'd2:    wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
    endcase
  end

  ////////////////////
  // misalignment
  ////////////////////

  // only the first part is flagged, bytes never cross a word
  always_comb
  begin
    misaligned_o = 1'b0;
    if (ex_req_i.req && !ex_req_i.misaligned_2nd)
    begin
      if ((ex_req_i.size == SIZE_WORD) && (addr_offset != 2'd0))
        misaligned_o = 1'b1;
      else if ((ex_req_i.size == SIZE_HALF) && (addr_offset == 2'd3))
        misaligned_o = 1'b1;
    end
  end

  // memory request fields, req driven by the controller at the top
  always_comb
  begin
    mem_req_o       = '0;
    mem_req_o.addr  = addr;
    mem_req_o.we    = ex_req_i.we;
    mem_req_o.be    = be;
    mem_req_o.wdata = wdata_rot;
  end

  assign offset_o = addr_offset;

endmodule

// File: hdl/lsu_load_path.sv
// load attribute capture, load data register, misaligned assembly and extension for the LSU top
`timescale 1ns/1ns

module lsu_load_path
  import lsu_types_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  ex_req_t ex_req_i,      // current execute request
  input  offset_t offset_i,      // address offset from the store path
  input  logic    mem_gnt_i,
  input  logic    mem_rvalid_i,
  input  word_t   mem_rdata_i,
  input  logic    misaligned_i,  // first part of a split access is out
  output word_t   ex_rdata_o     // load result to execute / writeback
);

  load_attr_t  attr_q;       // attributes of the access in flight
  word_t       rdata_q;      // raw first part or last finished result
  word_t       word_asm;     // word with spilled bytes merged in
  logic [15:0] half_sel;     // selected halfword before extension
  logic [7:0]  byte_sel;     // selected byte before extension
  word_t       rdata_ext;    // finished result

  ////////////////////
  // attribute capture
  ////////////////////

  // every grant overwrites, rvalid of that access comes later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      attr_q <= '0;
    end
    else if (mem_gnt_i)
    begin
      attr_q.size     <= ex_req_i.size;
      attr_q.offset   <= offset_i;
      attr_q.sign_ext <= ex_req_i.sign_ext;
      attr_q.we       <= ex_req_i.we;
    end
  end

  ////////////////////
  // alignment
  ////////////////////

  // second part brings the upper bytes, the register still holds the lower ones
  always_comb
  begin
    case (attr_q.offset)
      2'd0:    word_asm = mem_rdata_i;
      2'd1:    word_asm = {mem_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    word_asm = {mem_rdata_i[15:0], rdata_q[31:16]};
      default: word_asm = {mem_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (attr_q.offset)
      2'd0:    half_sel = mem_rdata_i[15:0];
      2'd1:    half_sel = mem_rdata_i[23:8];
      2'd2:    half_sel = mem_rdata_i[31:16];
      default: half_sel = {mem_rdata_i[7:0], rdata_q[31:24]};  // split halfword
    endcase
  end

  assign byte_sel = mem_rdata_i[8*attr_q.offset +: 8];

  ////////////////////
  // extension
  ////////////////////

  always_comb
  begin
    case (attr_q.size)
      SIZE_WORD: rdata_ext = word_asm;
      SIZE_HALF: rdata_ext = {{16{attr_q.sign_ext & half_sel[15]}}, half_sel};
      default:   rdata_ext = {{24{attr_q.sign_ext & byte_sel[7]}}, byte_sel};
    endcase
  end

  ////////////////////
  // load data register
  ////////////////////

  // first part of a split load keeps the raw word for assembly
  always_ff @(posedge clk)
  begin
    if (mem_rvalid_i && !attr_q.we)
    begin
      if (ex_req_i.misaligned_2nd || misaligned_i)
        rdata_q <= mem_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  // result passes straight through in the rvalid cycle, then held
  assign ex_rdata_o = mem_rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: hdl/lsu_req_ctrl.sv
// request FSM of the LSU, tracks one outstanding access and produces ready and busy
`timescale 1ns/1ns

module lsu_req_ctrl
(
  input  logic clk,
  input  logic rst_n,
  input  logic ex_req_valid_i,  // req field of the execute request
  input  logic ex_valid_i,      // execute stage advances this cycle
  input  logic mem_gnt_i,
  input  logic mem_rvalid_i,
  output logic mem_req_o,       // request bit to the memory port
  output logic ready_ex_o,      // execute may move on
  output logic ready_wb_o,      // writeback has its data
  output logic busy_o
);

  typedef enum logic [1:0] {
    IDLE              = 2'd0,  // nothing outstanding
    WAIT_RVALID       = 2'd1,  // granted, waiting for data
    WAIT_RVALID_STALL = 2'd2,  // granted while execute was stalled
    IDLE_STALL        = 2'd3   // data back, execute still stalled
  } state_e;

  state_e state_q, state_d;

  ////////////////////
  // state register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////
  // next state, outputs
  ////////////////////

  always_comb
  begin
    state_d    = state_q;
    mem_req_o  = 1'b0;
    ready_ex_o = 1'b1;
    ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        mem_req_o = ex_req_valid_i;     // same-cycle pass through
        if (ex_req_valid_i)
        begin
          ready_ex_o = mem_gnt_i;       // held until accepted
          if (mem_gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_STALL;
        end
      end

      WAIT_RVALID:
      begin
        ready_wb_o = mem_rvalid_i;
        if (mem_rvalid_i)
        begin
          // back-to-back access may go out with this rvalid
          mem_req_o = ex_req_valid_i;
          if (ex_req_valid_i)
          begin
            ready_ex_o = mem_gnt_i;
            if (mem_gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_STALL;
            else
              state_d = IDLE;           // retry from idle
          end
          else
          begin
            state_d = IDLE;
          end
        end
      end

      WAIT_RVALID_STALL:
      begin
        // no new request until execute is released
        if (mem_rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;
      end

      IDLE_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  // busy while anything is in flight or being asked for
  assign busy_o = (state_q != IDLE) || mem_req_o;

endmodule

// File: hdl/load_store_unit.sv
// top level of the load/store unit, sits between execute stage and data memory port
`timescale 1ns/1ns

module load_store_unit
  import lsu_types_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // execute stage
  input  ex_req_t  ex_req_i,
  input  logic     ex_valid_i,
  output word_t    ex_rdata_o,
  output logic     misaligned_o,   // to controller, split access needed
  output logic     ready_ex_o,
  output logic     ready_wb_o,
  output logic     busy_o,
  // data memory
  output mem_req_t mem_req_o,
  input  logic     mem_gnt_i,
  input  logic     mem_rvalid_i,
  input  word_t    mem_rdata_i
);

  mem_req_t store_req;   // address, we, be, wdata
  offset_t  cur_offset;  // offset of the address being presented
  logic     ctrl_req;    // request bit from the FSM

  lsu_store_path u_store_path (
    .ex_req_i     (ex_req_i),
    .mem_req_o    (store_req),
    .offset_o     (cur_offset),
    .misaligned_o (misaligned_o)
  );

  lsu_load_path u_load_path (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_req_i     (ex_req_i),
    .offset_i     (cur_offset),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .misaligned_i (misaligned_o),
    .ex_rdata_o   (ex_rdata_o)
  );

  lsu_req_ctrl u_req_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_req_valid_i (ex_req_i.req),
    .ex_valid_i     (ex_valid_i),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_req_o      (ctrl_req),
    .ready_ex_o     (ready_ex_o),
    .ready_wb_o     (ready_wb_o),
    .busy_o         (busy_o)
  );

  // request bit from the FSM, remaining fields from the store path
  always_comb
  begin
    mem_req_o     = store_req;
    mem_req_o.req = ctrl_req;
  end

endmodule

// File: verification/lsu_properties.sv
// concurrent checks of the LSU memory handshake and request FSM, bound into the LSU top level
`timescale 1ns/1ns

module lsu_properties
  import lsu_bus_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic [1:0] state_i,       // request FSM state
  input mem_req_t   mem_req_i,
  input logic       mem_gnt_i,
  input logic       mem_rvalid_i
);

  localparam logic [1:0] ST_IDLE        = 2'd0;
  localparam logic [1:0] ST_WAIT_RVALID = 2'd1;

  // back-to-back grant only together with the previous data
  gnt_needs_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_gnt_i && (state_i == ST_WAIT_RVALID)) |-> mem_rvalid_i)
    else $error("grant in WAIT_RVALID without rvalid");

  no_rvalid_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == ST_IDLE) |-> !mem_rvalid_i)
    else $error("rvalid while the request FSM is idle");

  addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i.req |-> !$isunknown(mem_req_i.addr))
    else $error("memory request with unknown address");

  ////////////////////
  // first cycle out of reset
  quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !mem_req_i.req)
    else $error("memory request raised right after reset");

endmodule

bind load_store_unit lsu_properties u_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .state_i      (u_req_ctrl.state_q),
  .mem_req_i    (mem_req_o),
  .mem_gnt_i    (mem_gnt_i),
  .mem_rvalid_i (mem_rvalid_i)
);

// File: verification/lsu_tb.sv
// directed testbench for the load/store unit with a 64-word data memory model, built from lsu.f
`timescale 1ns/1ns

module lsu_tb
  import lsu_types_pkg::*;
  import lsu_bus_pkg::*;
();

  logic     clk;
  logic     rst_n;
  ex_req_t  ex_req;
  logic     ex_valid;
  mem_req_t mem_req;
  logic     mem_gnt;
  logic     mem_rvalid;
  word_t    mem_rdata;
  word_t    ex_rdata;
  logic     misaligned;
  logic     ready_ex;
  logic     ready_wb;
  logic     busy;

  word_t       mem [64];      // memory model
  word_t       ref_mem [64];  // expected contents
  logic [31:0] rng;
  int          errors;
  int          checks;
  be_t         got_be;        // captured at grant
  word_t       got_addr;
  logic        got_mis;
  word_t       got_rdata;     // captured at rvalid

  load_store_unit DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_req_i     (ex_req),
    .ex_valid_i   (ex_valid),
    .ex_rdata_o   (ex_rdata),
    .misaligned_o (misaligned),
    .ready_ex_o   (ready_ex),
    .ready_wb_o   (ready_wb),
    .busy_o       (busy),
    .mem_req_o    (mem_req),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  assign mem_gnt = mem_req.req;  // slave never back-pressures

  ////////////////////
  // memory model
  initial
  begin : mem_model
    int         wait_cnt;
    logic       pending;
    logic [5:0] idx;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    pending    = 1'b0;
    wait_cnt   = 0;
    idx        = '0;
    for (int i = 0; i < 64; i++)
    begin
      mem[i]     = (32'h9e37_79b9 * (i + 1)) ^ (32'h0101_0101 * i);  // every bit of i matters
      ref_mem[i] = mem[i];
    end
    forever
    begin
      @(negedge clk);  // acceptance is stable mid-cycle
      if (rst_n && mem_req.req && mem_gnt)
      begin
        idx = mem_req.addr[7:2];
        for (int l = 0; l < 4; l++)
          if (mem_req.we && mem_req.be[l])
            mem[idx][8*l +: 8] = mem_req.wdata[8*l +: 8];
        rng      = xorshift32(rng);
        wait_cnt = 1 + int'(rng % 32'd3);  // 1 to 3 cycles
        pending  = 1'b1;
      end
      @(posedge clk);
      #1;
      mem_rvalid = 1'b0;
      if (pending)
      begin
        wait_cnt--;
        if (wait_cnt == 0)
        begin
          mem_rvalid = 1'b1;
          mem_rdata  = mem[idx];
          pending    = 1'b0;
        end
      end
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  function automatic int size_bytes(input size_e sz);
    case (sz)
      SIZE_WORD: return 4;
      SIZE_HALF: return 2;
      default:   return 1;
    endcase
  endfunction

  // lanes hit by bytes k..k+n-1, upper picks the part past the word boundary
  function automatic be_t lanes_for(input int k, input int n, input logic upper);
    be_t be;
    be = '0;
    for (int j = k; j < k + n; j++)
      if (upper == (j >= 4))
        be[j % 4] = 1'b1;
    return be;
  endfunction

  // little-endian bytes from the expected memory, then extension
  function automatic word_t load_expect(input word_t addr, input int n, input logic sx);
    word_t v;
    word_t a;
    v = '0;
    for (int j = 0; j < n; j++)
    begin
      a = addr + word_t'(j);
      v[8*j +: 8] = ref_mem[a[7:2]][8*a[1:0] +: 8];
    end
    for (int b = 8 * n; b < 32; b++)
      v[b] = sx & v[8*n-1];
    return v;
  endfunction

  // access byte j comes from register byte reg_off + j
  task automatic store_expect(input word_t addr, input int n, input word_t wd, input int reg_off);
    word_t a;
    for (int j = 0; j < n; j++)
    begin
      a = addr + word_t'(j);
      ref_mem[a[7:2]][8*a[1:0] +: 8] = wd[8*((reg_off + j) % 4) +: 8];
    end
  endtask

  // one memory access, called and left just after a rising edge
  task automatic run_access(input ex_req_t r, input logic keep_2nd);
    logic seen;
    seen   = 1'b0;
    ex_req = r;
    for (int n = 0; n < 16 && !seen; n++)
    begin
      @(negedge clk);
      if (mem_req.req && mem_gnt)
      begin
        seen     = 1'b1;
        got_be   = mem_req.be;
        got_addr = mem_req.addr;
        got_mis  = misaligned;
        check_word("ready_ex_o", 32'(ready_ex), 32'h1);
      end
    end
    if (!seen)
    begin
      $display("timeout while waiting for the memory grant");
      errors++;
    end
    @(posedge clk);
    #1;
    ex_req                = '0;
    ex_req.misaligned_2nd = keep_2nd;  // first part's data must be kept raw
    seen                  = 1'b0;
    for (int n = 0; n < 16 && !seen; n++)
    begin
      @(negedge clk);
      if (ex_valid)
        check_word("ready_wb_o", 32'(ready_wb), 32'(mem_rvalid));  // low until data is back
      if (mem_rvalid)
      begin
        seen      = 1'b1;
        got_rdata = ex_rdata;
      end
    end
    if (!seen)
    begin
      $display("timeout while waiting for the memory response");
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  // full access incl. second part when the bytes cross a word
  task automatic check_access(input logic we, input size_e sz, input word_t addr,
                              input int reg_off, input logic sx);
    ex_req_t r;
    int      n;
    int      k;
    logic    split;
    word_t   exp;
    n            = size_bytes(sz);
    k            = int'(addr[1:0]);
    split        = (k + n > 4);
    rng          = xorshift32(rng);
    r            = '0;
    r.req        = 1'b1;
    r.we         = we;
    r.size       = sz;
    r.wdata      = rng;
    r.reg_offset = offset_t'(reg_off);
    r.sign_ext   = sx;
    r.op_a       = addr - 32'h10;  // base plus increment
    r.op_b       = 32'h10;
    r.use_incr   = 1'b1;
    run_access(r, split);
    check_word("mem_req_o.addr", got_addr, addr);
    check_word("mem_req_o.be", 32'(got_be), 32'(lanes_for(k, n, 1'b0)));
    check_word("misaligned_o", 32'(got_mis), 32'(split));
    if (split)
    begin
      r.misaligned_2nd = 1'b1;
      r.op_a           = addr + 32'h4;
      r.use_incr       = 1'b0;
      run_access(r, 1'b0);
      check_word("mem_req_o.addr", got_addr, addr + 32'h4);
      check_word("mem_req_o.be", 32'(got_be), 32'(lanes_for(k, n, 1'b1)));
      check_word("misaligned_o", 32'(got_mis), 32'h0);
    end
    if (we)
    begin
      store_expect(addr, n, r.wdata, reg_off);
      check_word("memory word", mem[addr[7:2]], ref_mem[addr[7:2]]);
      check_word("memory word", mem[addr[7:2] + 6'd1], ref_mem[addr[7:2] + 6'd1]);
    end
    else
    begin
      exp = load_expect(addr, n, sx);
      check_word("ex_rdata_o", got_rdata, exp);
      @(negedge clk);
      check_word("ex_rdata_o", ex_rdata, exp);  // held after rvalid
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////
  // directed tests
  task automatic test_reset_and_word;
    @(negedge clk);
    check_word("mem_req_o.req", 32'(mem_req.req), 32'h0);
    check_word("busy_o", 32'(busy), 32'h0);
    check_word("ready_ex_o", 32'(ready_ex), 32'h1);
    check_word("ready_wb_o", 32'(ready_wb), 32'h1);
    @(posedge clk);
    #1;
    check_access(1'b1, SIZE_WORD, 32'h20, 0, 1'b0);
    check_access(1'b0, SIZE_WORD, 32'h20, 0, 1'b0);  // same word comes back
  endtask

  task automatic test_narrow_stores;
    for (int k = 0; k < 4; k++)
      check_access(1'b1, SIZE_BYTE, 32'h40 + k, (k % 3) + 1, 1'b0);
    for (int k = 0; k < 3; k++)
      check_access(1'b1, SIZE_HALF, 32'h50 + 5 * k, 3 - k, 1'b0);
  endtask

  task automatic test_narrow_loads;
    for (int sx = 0; sx < 2; sx++)
    begin
      for (int k = 0; k < 4; k++)
        check_access(1'b0, SIZE_BYTE, 32'h60 + 5 * k, 0, sx[0]);
      for (int k = 0; k < 3; k++)
        check_access(1'b0, SIZE_HALF, 32'h70 + 5 * k, 0, sx[0]);
    end
  endtask

  task automatic test_misaligned;
    for (int k = 1; k < 4; k++)
    begin
      check_access(1'b1, SIZE_WORD, 32'h80 + 5 * k, k - 1, 1'b0);
      check_access(1'b0, SIZE_WORD, 32'h80 + 5 * k, 0, 1'b0);
    end
    check_access(1'b1, SIZE_HALF, 32'h9b, 2, 1'b0);
    check_access(1'b0, SIZE_HALF, 32'h9b, 0, 1'b1);
    check_access(1'b0, SIZE_HALF, 32'hab, 0, 1'b1);  // fill data with bit 15 set
    check_access(1'b0, SIZE_HALF, 32'hab, 0, 1'b0);
  endtask

  // execute held at grant, FSM parks in the stall states
  task automatic test_stall;
    ex_req_t r;
    word_t   exp;
    exp      = load_expect(32'hc8, 4, 1'b0);
    r        = '0;
    r.req    = 1'b1;
    r.size   = SIZE_WORD;
    r.op_a   = 32'hc8;
    ex_valid = 1'b0;
    run_access(r, 1'b0);
    check_word("ex_rdata_o", got_rdata, exp);
    for (int i = 0; i < 3; i++)
    begin
      @(negedge clk);
      check_word("busy_o", 32'(busy), 32'h1);
    end
    @(posedge clk);
    #1;
    ex_valid = 1'b1;
    for (int n = 0; n < 8 && busy; n++)
      @(negedge clk);
    if (busy)
    begin
      $display("timeout while waiting for busy_o to drop after the stall");
      errors++;
    end
    check_word("ex_rdata_o", ex_rdata, exp);
  endtask

  initial
  begin
    rng      = 32'h845e_d28f;
    errors   = 0;
    checks   = 0;
    rst_n    = 1'b0;
    ex_req   = '0;
    ex_valid = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_and_word();
    test_narrow_stores();
    test_narrow_loads();
    test_misaligned();
    test_stall();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // hard stop in case a wait loop is never reached
  initial
  begin
    #200000;
    $display("simulation watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: lsu.f
hdl/lsu_types_pkg.sv
hdl/lsu_bus_pkg.sv
hdl/lsu_store_path.sv
hdl/lsu_load_path.sv
hdl/lsu_req_ctrl.sv
hdl/load_store_unit.sv
verification/lsu_properties.sv
verification/lsu_tb.sv

// File: run.sh
#!/bin/sh
# builds the LSU testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -Mdir obj_dir -f lsu.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vlsu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
